//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // ----------------------------------------
  // architectural widths
  // ----------------------------------------
  // integer data path width
  localparam int unsigned XLEN = 32;
  // program counter width
  localparam int unsigned VLEN = 32;
  // architectural register index width
  localparam int unsigned REG_ADDR_BITS = 5;
  // number of integer registers, x0 included
  localparam int unsigned NR_REGS = 2 ** REG_ADDR_BITS;
  // scoreboard slot tag width
  localparam int unsigned TRANS_ID_BITS = 3;

  // ----------------------------------------
  // scalar types
  // ----------------------------------------
  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [VLEN-1:0] vaddr_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

endpackage

`default_nettype wire

//--- hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;
  import isa_pkg::*;

  // ----------------------------------------
  // functional units and operations
  // ----------------------------------------
  // target unit of an entry, FU_NONE needs no unit at all
  typedef enum logic [2:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE,
    FU_ALU,
    FU_CTRL_FLOW,
    FU_MULT,
    FU_CSR
  } fu_t;

  // operation subset, OP_ADD is the reset value of the launch register
  typedef enum logic [6:0] {
    OP_ADD,
    OP_SUB,
    OP_XORL,
    OP_ORL,
    OP_ANDL,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_EQ,
    OP_NE,
    OP_LTS,
    OP_GES,
    OP_LTU,
    OP_GEU,
    OP_MUL,
    OP_MULH,
    OP_LW,
    OP_SW,
    OP_CSR_READ,
    OP_CSR_WRITE
  } fu_op_t;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  // decoded entry handed over by the scoreboard
  typedef struct packed {
    vaddr_t    pc;
    fu_t       fu;
    fu_op_t    op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    // carries the immediate
    xlen_t     result;
    trans_id_t trans_id;
    logic      use_imm;
    logic      use_pc;
    logic      use_zimm;
    logic      ex_valid;
  } issue_entry_t;

  // pending writer of each register, FU_NONE when nothing is in flight
  typedef fu_t [NR_REGS-1:0] clobber_t;

  // operand bundle toward the units
  typedef struct packed {
    fu_t       fu;
    fu_op_t    op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

  // one launch valid per unit
  typedef struct packed {
    logic alu;
    logic branch;
    logic mult;
    logic lsu;
    logic csr;
  } fu_valid_t;

  // per-source forwarding select
  typedef struct packed {
    logic fwd_rs1;
    logic fwd_rs2;
  } operand_src_t;

endpackage

`default_nettype wire

//--- hdl/int_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module int_regfile
  import isa_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  // read ports, combinational
  input  wire reg_addr_t                        raddr_a_i,
  input  wire reg_addr_t                        raddr_b_i,
  output xlen_t                                 rdata_a_o,
  output xlen_t                                 rdata_b_o,
  // commit write ports
  input  wire logic      [NR_COMMIT_PORTS-1:0] we_i,
  input  wire reg_addr_t [NR_COMMIT_PORTS-1:0] waddr_i,
  input  wire xlen_t     [NR_COMMIT_PORTS-1:0] wdata_i
);

  // x1 .. x31 only, x0 has no storage
  xlen_t regs_q [1:NR_REGS-1];

  // ----------------------------------------
  // write side
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 1; r < NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // ports are visited in order, so the highest port wins a collision
      for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
        // writes to x0 are dropped
        if (we_i[p] && (waddr_i[p] != '0)) begin
          regs_q[waddr_i[p]] <= wdata_i[p];
        end
      end
    end
  end

  // ----------------------------------------
  // read side
  // ----------------------------------------
  // x0 is hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- hdl/operand_hazard.sv
`default_nettype none
`timescale 1ns/1ps

module operand_hazard
  import issue_pkg::*;
(
  input  wire issue_entry_t entry_i,
  // pending writers from the scoreboard
  input  wire clobber_t     clobber_i,
  // forwarded result availability
  input  wire logic         rs1_fwd_valid_i,
  input  wire logic         rs2_fwd_valid_i,
  output operand_src_t      src_o,
  output logic              stall_o
);

  // pending writer of each source
  fu_t rs1_writer;
  fu_t rs2_writer;
  // source has an instruction in flight that writes it
  logic rs1_pending;
  logic rs2_pending;
  // in-flight result can be taken from the scoreboard
  logic rs1_fwd_ok;
  logic rs2_fwd_ok;

  // ----------------------------------------
  // clobber lookup
  // ----------------------------------------
  assign rs1_writer = clobber_i[entry_i.rs1];
  assign rs2_writer = clobber_i[entry_i.rs2];

  // rs1 holds the zimm itself, so it depends on nothing then
  assign rs1_pending = !entry_i.use_zimm && (rs1_writer != FU_NONE);
  assign rs2_pending = (rs2_writer != FU_NONE);

  // CSR results only reach us through the register file
  assign rs1_fwd_ok = rs1_fwd_valid_i && (rs1_writer != FU_CSR);
  assign rs2_fwd_ok = rs2_fwd_valid_i && (rs2_writer != FU_CSR);

  // ----------------------------------------
  // forward or stall
  // ----------------------------------------
  always_comb begin : operands_available
    src_o   = '0;
    stall_o = 1'b0;
    // source 1
    if (rs1_pending) begin
      if (rs1_fwd_ok) begin
        src_o.fwd_rs1 = 1'b1;
      end else begin
        // value not produced yet, wait for it
        stall_o = 1'b1;
      end
    end
    // source 2
    if (rs2_pending) begin
      if (rs2_fwd_ok) begin
        src_o.fwd_rs2 = 1'b1;
      end else begin
        stall_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
`default_nettype none
`timescale 1ns/1ps

module operand_select
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  wire issue_entry_t entry_i,
  input  wire operand_src_t src_i,
  // register file read data
  input  wire xlen_t        rf_a_i,
  input  wire xlen_t        rf_b_i,
  // forwarded scoreboard results
  input  wire xlen_t        fwd_a_i,
  input  wire xlen_t        fwd_b_i,
  output fu_data_t          data_o
);

  // ----------------------------------------
  // operand mux
  // ----------------------------------------
  // later assignments take priority
  always_comb begin : forwarding_operand_select
    // register file by default
    data_o.operand_a = rf_a_i;
    data_o.operand_b = rf_b_i;
    // store and branch offsets travel in imm
    data_o.imm       = entry_i.result;
    data_o.fu        = entry_i.fu;
    data_o.op        = entry_i.op;
    data_o.trans_id  = entry_i.trans_id;
    // in-flight results
    if (src_i.fwd_rs1) begin
      data_o.operand_a = fwd_a_i;
    end
    if (src_i.fwd_rs2) begin
      data_o.operand_b = fwd_b_i;
    end
    // pc operand of auipc and jal sign extended to xlen
    if (entry_i.use_pc) begin
      data_o.operand_a = xlen_t'(signed'(entry_i.pc));
    end
    // csr immediate form zero extends the index
    if (entry_i.use_zimm) begin
      data_o.operand_a = xlen_t'(entry_i.rs1);
    end
    // stores and branches keep rs2 in operand b
    if (entry_i.use_imm && (entry_i.fu != FU_STORE) && (entry_i.fu != FU_CTRL_FLOW)) begin
      data_o.operand_b = entry_i.result;
    end
  end

endmodule

`default_nettype wire

//--- hdl/issue_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module issue_ctrl
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  wire issue_entry_t                    entry_i,
  input  wire logic                            issue_valid_i,
  // operand not available
  input  wire logic                            stall_i,
  input  wire clobber_t                        clobber_i,
  // unit readiness
  input  wire logic                            flu_ready_i,
  input  wire logic                            lsu_ready_i,
  // commit writes in this cycle
  input  wire logic      [NR_COMMIT_PORTS-1:0] commit_we_i,
  input  wire reg_addr_t [NR_COMMIT_PORTS-1:0] commit_waddr_i,
  // a multiply is being launched
  input  wire logic                            mult_busy_i,
  output logic                                 issue_ack_o,
  output logic                                 issue_fire_o
);

  logic fu_busy;
  // rd is written back by a commit port right now
  logic rd_commit;
  // no write-after-write hazard on rd
  logic rd_free;

  // ----------------------------------------
  // busy signal of the target unit
  // ----------------------------------------
  always_comb begin : unit_busy
    case (entry_i.fu)
      FU_ALU, FU_CTRL_FLOW, FU_MULT, FU_CSR: fu_busy = !flu_ready_i;
      FU_LOAD, FU_STORE:                     fu_busy = !lsu_ready_i;
      default:                               fu_busy = 1'b0;
    endcase
  end

  // ----------------------------------------
  // write-after-write check
  // ----------------------------------------
  always_comb begin : waw_check
    rd_commit = 1'b0;
    for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (commit_we_i[p] && (commit_waddr_i[p] == entry_i.rd)) begin
        rd_commit = 1'b1;
      end
    end
  end

  // the pending writer retires this cycle, so the hazard is gone
  assign rd_free = (clobber_i[entry_i.rd] == FU_NONE) || rd_commit;

  // ----------------------------------------
  // acceptance
  // ----------------------------------------
  always_comb begin : issue_accept
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      if (!stall_i && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less entries only pass through
      if (entry_i.ex_valid || (entry_i.fu == FU_NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // the multiplier shares the fixed latency result bus
    if (mult_busy_i && (entry_i.fu inside {FU_ALU, FU_CTRL_FLOW, FU_CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

  // only real work reaches a unit
  assign issue_fire_o = issue_valid_i && issue_ack_o && !entry_i.ex_valid &&
                        (entry_i.fu != FU_NONE);

endmodule

`default_nettype wire

//--- hdl/fu_dispatch_reg.sv
`default_nettype none
`timescale 1ns/1ps

module fu_dispatch_reg
  import issue_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // kill whatever is launched next
  input  wire logic     flush_i,
  // accepted entry that needs a unit
  input  wire logic     issue_fire_i,
  input  wire fu_data_t data_i,
  output fu_data_t      fu_data_o,
  output fu_valid_t     fu_valid_o,
  output logic          mult_busy_o
);

  fu_data_t  data_q;
  fu_valid_t valid_q;

  // ----------------------------------------
  // operand register
  // ----------------------------------------
  // loaded every cycle, the valids qualify it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
    end else begin
      data_q <= data_i;
    end
  end

  // ----------------------------------------
  // launch valids
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      // single cycle pulse
      valid_q <= '0;
      if (issue_fire_i) begin
        case (data_i.fu)
          FU_ALU:            valid_q.alu    <= 1'b1;
          FU_CTRL_FLOW:      valid_q.branch <= 1'b1;
          FU_MULT:           valid_q.mult   <= 1'b1;
          // loads and stores share the lsu
          FU_LOAD, FU_STORE: valid_q.lsu    <= 1'b1;
          FU_CSR:            valid_q.csr    <= 1'b1;
          default:           valid_q        <= '0;
        endcase
      end
      // otherwise a unit starts on a squashed entry
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  assign fu_data_o   = data_q;
  assign fu_valid_o  = valid_q;
  // issue_ctrl blocks fixed latency entries behind a multiply
  assign mult_busy_o = valid_q.mult;

endmodule

`default_nettype wire

//--- hdl/issue_read_operands.sv
`default_nettype none
`timescale 1ns/1ps

module issue_read_operands
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            flush_i,
  // issue handshake
  input  wire issue_entry_t                    issue_entry_i,
  input  wire logic                            issue_valid_i,
  output logic                                 issue_ack_o,
  // scoreboard lookup
  output reg_addr_t                            rs1_o,
  output reg_addr_t                            rs2_o,
  input  wire clobber_t                        clobber_i,
  input  wire xlen_t                           rs1_fwd_i,
  input  wire logic                            rs1_fwd_valid_i,
  input  wire xlen_t                           rs2_fwd_i,
  input  wire logic                            rs2_fwd_valid_i,
  // commit writes
  input  wire logic      [NR_COMMIT_PORTS-1:0] commit_we_i,
  input  wire reg_addr_t [NR_COMMIT_PORTS-1:0] commit_waddr_i,
  input  wire xlen_t     [NR_COMMIT_PORTS-1:0] commit_wdata_i,
  // unit side
  input  wire logic                            flu_ready_i,
  input  wire logic                            lsu_ready_i,
  output fu_data_t                             fu_data_o,
  output fu_valid_t                            fu_valid_o
);

  xlen_t        rf_rdata_a;
  xlen_t        rf_rdata_b;
  operand_src_t operand_src;
  logic         operand_stall;
  fu_data_t     operand_data;
  logic         issue_fire;
  logic         mult_busy;

  // the scoreboard is polled with the entry's own sources
  assign rs1_o = issue_entry_i.rs1;
  assign rs2_o = issue_entry_i.rs2;

  // ----------------------------------------
  // register read
  // ----------------------------------------
  int_regfile #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) i_int_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(issue_entry_i.rs1),
    .raddr_b_i(issue_entry_i.rs2),
    .rdata_a_o(rf_rdata_a),
    .rdata_b_o(rf_rdata_b),
    .we_i     (commit_we_i),
    .waddr_i  (commit_waddr_i),
    .wdata_i  (commit_wdata_i)
  );

  operand_hazard i_operand_hazard (
    .entry_i        (issue_entry_i),
    .clobber_i      (clobber_i),
    .rs1_fwd_valid_i(rs1_fwd_valid_i),
    .rs2_fwd_valid_i(rs2_fwd_valid_i),
    .src_o          (operand_src),
    .stall_o        (operand_stall)
  );

  operand_select i_operand_select (
    .entry_i(issue_entry_i),
    .src_i  (operand_src),
    .rf_a_i (rf_rdata_a),
    .rf_b_i (rf_rdata_b),
    .fwd_a_i(rs1_fwd_i),
    .fwd_b_i(rs2_fwd_i),
    .data_o (operand_data)
  );

  // ----------------------------------------
  // issue and launch
  // ----------------------------------------
  issue_ctrl #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) i_issue_ctrl (
    .entry_i       (issue_entry_i),
    .issue_valid_i (issue_valid_i),
    .stall_i       (operand_stall),
    .clobber_i     (clobber_i),
    .flu_ready_i   (flu_ready_i),
    .lsu_ready_i   (lsu_ready_i),
    .commit_we_i   (commit_we_i),
    .commit_waddr_i(commit_waddr_i),
    .mult_busy_i   (mult_busy),
    .issue_ack_o   (issue_ack_o),
    .issue_fire_o  (issue_fire)
  );

  fu_dispatch_reg i_fu_dispatch_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .issue_fire_i(issue_fire),
    .data_i      (operand_data),
    .fu_data_o   (fu_data_o),
    .fu_valid_o  (fu_valid_o),
    .mult_busy_o (mult_busy)
  );

endmodule

`default_nettype wire

//--- tb/issue_read_operands_properties.sv
`default_nettype none
`timescale 1ns/1ps

module issue_read_operands_properties
  import issue_pkg::*;
(
  input wire logic         clk_i,
  input wire logic         rst_ni,
  input wire logic         flush_i,
  input wire issue_entry_t issue_entry_i,
  input wire logic         issue_valid_i,
  input wire logic         issue_ack_o,
  input wire fu_valid_t    fu_valid_o
);

  // failed assertions so far, the testbench reads this at the end
  int unsigned failures = 0;
  // accepted entry that needs a unit
  logic        fire;
  // units that share the result bus with the multiplier
  logic        fixed_latency;

  assign fire = issue_valid_i && issue_ack_o && !issue_entry_i.ex_valid &&
                (issue_entry_i.fu != FU_NONE);
  assign fixed_latency = (issue_entry_i.fu == FU_ALU) || (issue_entry_i.fu == FU_CTRL_FLOW) ||
                         (issue_entry_i.fu == FU_CSR);

  // ----------------------------------------
  // launch timing
  // ----------------------------------------
  launch_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fire && !flush_i) |=> (fu_valid_o != '0))
  else begin
    $error("accepted entry was not launched one cycle later");
    failures++;
  end

  // each valid is a pulse caused by an accept
  launch_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fu_valid_o != '0) |-> $past(fire && !flush_i))
  else begin
    $error("launch valid without an accept in the previous cycle");
    failures++;
  end

  single_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(fu_valid_o))
  else begin
    $error("more than one launch valid is high");
    failures++;
  end

  flush_kills_launch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (fu_valid_o == '0))
  else begin
    $error("launch valid after a flush");
    failures++;
  end

  // ----------------------------------------
  // multiply rule and reset
  // ----------------------------------------
  no_ack_behind_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fu_valid_o.mult && fixed_latency) |-> !issue_ack_o)
  else begin
    $error("fixed latency entry acked while a multiply launches");
    failures++;
  end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (fu_valid_o == '0))
  else begin
    $error("launch valid high during reset");
    failures++;
  end

endmodule

bind issue_read_operands issue_read_operands_properties i_properties (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .flush_i      (flush_i),
  .issue_entry_i(issue_entry_i),
  .issue_valid_i(issue_valid_i),
  .issue_ack_o  (issue_ack_o),
  .fu_valid_o   (fu_valid_o)
);

`default_nettype wire

//--- tb/tb_issue_read_operands.sv
`default_nettype none
`timescale 1ns/1ps

module tb_issue_read_operands
  import isa_pkg::*;
  import issue_pkg::*;
();

  localparam int unsigned NR_COMMIT_PORTS = 2;
  // cycles an entry may wait for its ack
  localparam int unsigned WAIT_LIMIT = 20;

  localparam fu_valid_t V_NONE   = '0;
  localparam fu_valid_t V_ALU    = '{alu: 1'b1, default: 1'b0};
  localparam fu_valid_t V_BRANCH = '{branch: 1'b1, default: 1'b0};
  localparam fu_valid_t V_MULT   = '{mult: 1'b1, default: 1'b0};
  localparam fu_valid_t V_LSU    = '{lsu: 1'b1, default: 1'b0};
  localparam fu_valid_t V_CSR    = '{csr: 1'b1, default: 1'b0};

  logic                             clk_i;
  logic                             rst_ni;
  logic                             flush_i;
  issue_entry_t                     issue_entry_i;
  logic                             issue_valid_i;
  logic                             issue_ack_o;
  reg_addr_t                        rs1_o;
  reg_addr_t                        rs2_o;
  clobber_t                         clobber_i;
  xlen_t                            rs1_fwd_i;
  logic                             rs1_fwd_valid_i;
  xlen_t                            rs2_fwd_i;
  logic                             rs2_fwd_valid_i;
  logic      [NR_COMMIT_PORTS-1:0] commit_we_i;
  reg_addr_t [NR_COMMIT_PORTS-1:0] commit_waddr_i;
  xlen_t     [NR_COMMIT_PORTS-1:0] commit_wdata_i;
  logic                             flu_ready_i;
  logic                             lsu_ready_i;
  fu_data_t                         fu_data_o;
  fu_valid_t                        fu_valid_o;

  // architectural state as the testbench expects it
  xlen_t        shadow [NR_REGS];
  // entry currently offered to the DUT
  issue_entry_t cur_entry;
  trans_id_t    next_tid;
  int           seed = 32'hf822;
  int unsigned  errors;
  int unsigned  checks;

  issue_read_operands #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .issue_entry_i  (issue_entry_i),
    .issue_valid_i  (issue_valid_i),
    .issue_ack_o    (issue_ack_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .clobber_i      (clobber_i),
    .rs1_fwd_i      (rs1_fwd_i),
    .rs1_fwd_valid_i(rs1_fwd_valid_i),
    .rs2_fwd_i      (rs2_fwd_i),
    .rs2_fwd_valid_i(rs2_fwd_valid_i),
    .commit_we_i    (commit_we_i),
    .commit_waddr_i (commit_waddr_i),
    .commit_wdata_i (commit_wdata_i),
    .flu_ready_i    (flu_ready_i),
    .lsu_ready_i    (lsu_ready_i),
    .fu_data_o      (fu_data_o),
    .fu_valid_o     (fu_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic issue_entry_t new_entry(input fu_t fu, input fu_op_t op,
                                             input reg_addr_t rs1, input reg_addr_t rs2,
                                             input reg_addr_t rd, input xlen_t imm);
    issue_entry_t e;
    e          = '0;
    e.pc       = 32'h8000_0100;
    e.fu       = fu;
    e.op       = op;
    e.rs1      = rs1;
    e.rs2      = rs2;
    e.rd       = rd;
    e.result   = imm;
    e.trans_id = next_tid;
    next_tid   = next_tid + 1'b1;
    return e;
  endfunction

  task automatic check_value(input string name, input string field,
                             input xlen_t exp_v, input xlen_t act_v);
    checks++;
    assert (act_v === exp_v) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", name, field, exp_v, act_v);
      errors++;
    end
  endtask

  // both ports in one cycle with port 1 landing last
  task automatic commit_write(input reg_addr_t addr0, input xlen_t data0,
                              input reg_addr_t addr1, input xlen_t data1);
    @(posedge clk_i);
    commit_we_i    <= 2'b11;
    commit_waddr_i <= {addr1, addr0};
    commit_wdata_i <= {data1, data0};
    @(posedge clk_i);
    commit_we_i    <= '0;
    if (addr0 != '0) begin
      shadow[addr0] = data0;
    end
    if (addr1 != '0) begin
      shadow[addr1] = data1;
    end
  endtask

  task automatic start_issue(input issue_entry_t e);
    @(posedge clk_i);
    issue_entry_i <= e;
    issue_valid_i <= 1'b1;
    cur_entry = e;
  endtask

  // ack has to stay low for n cycles
  task automatic hold_check(input string name, input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      check_value(name, "ack", '0, xlen_t'(issue_ack_o));
    end
  endtask

  task automatic wait_ack(input string name, output bit ok);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (!issue_ack_o && (waited < WAIT_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    ok = issue_ack_o;
    if (!ok) begin
      $display("timeout: %s was not acknowledged within %0d cycles", name, WAIT_LIMIT);
      errors++;
    end
  endtask

  // accept on the next edge, then look at the launch one cycle later
  task automatic accept_and_check(input string name, input xlen_t exp_a,
                                  input xlen_t exp_b, input fu_valid_t exp_v);
    bit ok;
    wait_ack(name, ok);
    // scoreboard lookup indices follow the offered entry
    check_value(name, "rs1_o", xlen_t'(cur_entry.rs1), xlen_t'(rs1_o));
    check_value(name, "rs2_o", xlen_t'(cur_entry.rs2), xlen_t'(rs2_o));
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    if (ok) begin
      @(negedge clk_i);
      check_value(name, "valid", xlen_t'(exp_v), xlen_t'(fu_valid_o));
      if (exp_v != '0) begin
        check_value(name, "fu", xlen_t'(cur_entry.fu), xlen_t'(fu_data_o.fu));
        check_value(name, "op", xlen_t'(cur_entry.op), xlen_t'(fu_data_o.op));
        check_value(name, "operand_a", exp_a, fu_data_o.operand_a);
        check_value(name, "operand_b", exp_b, fu_data_o.operand_b);
        check_value(name, "imm", cur_entry.result, fu_data_o.imm);
        check_value(name, "trans_id", xlen_t'(cur_entry.trans_id), xlen_t'(fu_data_o.trans_id));
      end
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    issue_entry_t e;
    xlen_t        value;
    bit           ok;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    issue_entry_i   = '0;
    issue_valid_i   = 1'b0;
    rs1_fwd_i       = '0;
    rs1_fwd_valid_i = 1'b0;
    rs2_fwd_i       = '0;
    rs2_fwd_valid_i = 1'b0;
    commit_we_i     = '0;
    commit_waddr_i  = '0;
    commit_wdata_i  = '0;
    flu_ready_i     = 1'b1;
    lsu_ready_i     = 1'b1;
    next_tid        = '0;
    errors          = 0;
    checks          = 0;
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      clobber_i[r] = FU_NONE;
      shadow[r]    = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // fill x1..x31 and let the last pair hit x0
    for (int unsigned r = 1; r < NR_REGS; r += 2) begin
      commit_write(reg_addr_t'(r), $random(seed), reg_addr_t'(r + 1), $random(seed));
    end
    // collision on x7
    commit_write(5'd7, $random(seed), 5'd7, $random(seed));

    // register read where x0 reads zero
    start_issue(new_entry(FU_ALU, OP_ADD, 5'd0, 5'd7, 5'd20, '0));
    accept_and_check("read x0/x7", '0, shadow[7], V_ALU);
    start_issue(new_entry(FU_ALU, OP_XORL, 5'd1, 5'd2, 5'd20, '0));
    accept_and_check("read x1/x2", shadow[1], shadow[2], V_ALU);

    // random register pairs and immediates
    repeat (6) begin
      e = new_entry(FU_ALU, OP_ORL, reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                    5'd20, $random(seed));
      e.use_imm = 1'($random(seed));
      start_issue(e);
      accept_and_check("random alu", shadow[e.rs1], e.use_imm ? e.result : shadow[e.rs2],
                       V_ALU);
    end

    // ----------------------------------------
    // forwarding
    // ----------------------------------------
    value = $random(seed);
    @(posedge clk_i);
    clobber_i[9]    <= FU_ALU;
    clobber_i[10]   <= FU_MULT;
    rs1_fwd_i       <= value;
    rs1_fwd_valid_i <= 1'b1;
    rs2_fwd_i       <= ~value;
    rs2_fwd_valid_i <= 1'b1;
    start_issue(new_entry(FU_ALU, OP_SUB, 5'd9, 5'd10, 5'd21, '0));
    accept_and_check("forward rs1/rs2", value, ~value, V_ALU);
    // forward not ready yet
    @(posedge clk_i);
    clobber_i[10]   <= FU_NONE;
    rs1_fwd_valid_i <= 1'b0;
    rs2_fwd_valid_i <= 1'b0;
    start_issue(new_entry(FU_ALU, OP_SUB, 5'd9, 5'd10, 5'd21, '0));
    hold_check("forward invalid", 3);
    @(posedge clk_i);
    clobber_i[9] <= FU_NONE;
    accept_and_check("forward invalid", shadow[9], shadow[10], V_ALU);
    // csr results never forward
    @(posedge clk_i);
    clobber_i[11]   <= FU_CSR;
    rs2_fwd_i       <= $random(seed);
    rs2_fwd_valid_i <= 1'b1;
    start_issue(new_entry(FU_ALU, OP_ANDL, 5'd12, 5'd11, 5'd21, '0));
    hold_check("csr clobber", 3);
    @(posedge clk_i);
    clobber_i[11]   <= FU_NONE;
    rs2_fwd_valid_i <= 1'b0;
    accept_and_check("csr clobber", shadow[12], shadow[11], V_ALU);

    // ----------------------------------------
    // operand mux and back-pressure
    // ----------------------------------------
    e         = new_entry(FU_ALU, OP_ADD, 5'd1, 5'd2, 5'd22, $random(seed));
    e.pc      = $random(seed);
    e.use_pc  = 1'b1;
    e.use_imm = 1'b1;
    start_issue(e);
    // pc and data share one width here
    accept_and_check("use_pc", e.pc, e.result, V_ALU);
    // zimm ignores whatever writes rs1
    @(posedge clk_i);
    clobber_i[19] <= FU_LOAD;
    e          = new_entry(FU_CSR, OP_CSR_WRITE, 5'd19, 5'd0, 5'd23, '0);
    e.use_zimm = 1'b1;
    start_issue(e);
    accept_and_check("use_zimm", 32'd19, '0, V_CSR);
    @(posedge clk_i);
    clobber_i[19] <= FU_NONE;
    lsu_ready_i   <= 1'b0;
    e         = new_entry(FU_STORE, OP_SW, 5'd3, 5'd4, 5'd0, $random(seed));
    e.use_imm = 1'b1;
    start_issue(e);
    hold_check("store lsu busy", 2);
    @(posedge clk_i);
    lsu_ready_i <= 1'b1;
    accept_and_check("store lsu busy", shadow[3], shadow[4], V_LSU);
    // branches keep rs2 in operand b as well
    e         = new_entry(FU_CTRL_FLOW, OP_EQ, 5'd7, 5'd8, 5'd0, $random(seed));
    e.use_imm = 1'b1;
    start_issue(e);
    accept_and_check("branch imm", shadow[7], shadow[8], V_BRANCH);
    @(posedge clk_i);
    flu_ready_i <= 1'b0;
    start_issue(new_entry(FU_ALU, OP_SLL, 5'd5, 5'd6, 5'd22, '0));
    hold_check("alu flu busy", 2);
    @(posedge clk_i);
    flu_ready_i <= 1'b1;
    accept_and_check("alu flu busy", shadow[5], shadow[6], V_ALU);

    // ----------------------------------------
    // write-after-write and pass-through
    // ----------------------------------------
    value = $random(seed);
    @(posedge clk_i);
    clobber_i[24] <= FU_LOAD;
    start_issue(new_entry(FU_ALU, OP_ADD, 5'd5, 5'd6, 5'd24, '0));
    hold_check("waw", 2);
    // the pending writer of rd commits now
    @(posedge clk_i);
    commit_we_i       <= 2'b10;
    commit_waddr_i[1] <= 5'd24;
    commit_wdata_i[1] <= value;
    accept_and_check("waw", shadow[5], shadow[6], V_ALU);
    @(posedge clk_i);
    commit_we_i   <= '0;
    clobber_i[24] <= FU_NONE;
    shadow[24] = value;
    @(posedge clk_i);
    clobber_i[25] <= FU_LOAD;
    e          = new_entry(FU_ALU, OP_ADD, 5'd25, 5'd25, 5'd25, '0);
    e.ex_valid = 1'b1;
    start_issue(e);
    accept_and_check("exception", '0, '0, V_NONE);
    start_issue(new_entry(FU_NONE, OP_ADD, 5'd25, 5'd25, 5'd25, '0));
    accept_and_check("no unit", '0, '0, V_NONE);
    @(posedge clk_i);
    clobber_i[25] <= FU_NONE;

    // ----------------------------------------
    // multiply rule and flush
    // ----------------------------------------
    start_issue(new_entry(FU_MULT, OP_MUL, 5'd3, 5'd4, 5'd12, '0));
    wait_ack("mult", ok);
    @(posedge clk_i);
    // an alu entry follows right behind the multiply
    e = new_entry(FU_ALU, OP_ADD, 5'd5, 5'd6, 5'd13, '0);
    issue_entry_i <= e;
    cur_entry = e;
    @(negedge clk_i);
    if (ok) begin
      check_value("mult", "valid", xlen_t'(V_MULT), xlen_t'(fu_valid_o));
      check_value("mult", "operand_a", shadow[3], fu_data_o.operand_a);
    end
    check_value("alu after mult", "ack", '0, xlen_t'(issue_ack_o));
    accept_and_check("alu after mult", shadow[5], shadow[6], V_ALU);
    // flush is sampled on the accepting edge
    @(posedge clk_i);
    flush_i <= 1'b1;
    start_issue(new_entry(FU_ALU, OP_ADD, 5'd1, 5'd2, 5'd20, '0));
    accept_and_check("flush", '0, '0, V_NONE);
    @(posedge clk_i);
    flush_i <= 1'b0;
    repeat (2) @(posedge clk_i);

    $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
             checks, errors, dut.i_properties.failures);
    if ((errors == 0) && (dut.i_properties.failures == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/int_regfile.sv
hdl/operand_hazard.sv
hdl/operand_select.sv
hdl/issue_ctrl.sv
hdl/fu_dispatch_reg.sv
hdl/issue_read_operands.sv
tb/issue_read_operands_properties.sv
tb/tb_issue_read_operands.sv

//--- Makefile
# Verilator flow for the register-read and issue stage

VERILATOR ?= verilator
TOP       ?= tb_issue_read_operands
RTL_TOP   ?= issue_read_operands
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= *** TEST FAILED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# fails on the fail message in the log or on a simulator error status
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	test $$status -eq 0

clean:
	rm -rf $(BUILD_DIR) $(LOG)
